// ==== rs_pkg.sv ====
package rs_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Physical register tag, 64 registers
  localparam int tag_w = 6;

  // Instruction word
  localparam int inst_w = 32;

  // Functional-unit classes served by the station
  localparam int num_fu = 5;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Unit class of a dispatched instruction
  // Also the index of the per-class issue ports
  typedef enum logic [2:0] {
    fu_alu  = 3'b000,
    fu_st   = 3'b001,
    fu_ld   = 3'b010,
    fu_mult = 3'b011,
    fu_br   = 3'b100
  } fu_t;

  // ALU operation carried along with the instruction
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,
    alu_bis    = 5'h04,
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_mulq   = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmplt  = 5'h0d,
    alu_cmple  = 5'h0e,
    alu_cmpult = 5'h0f,
    alu_cmpule = 5'h10
  } alu_func_t;

  // No-op word, also what an empty slot holds
  localparam logic [inst_w-1:0] noop_inst = 32'h47ff041f;

endpackage

// ==== rs_entry.sv ====
`timescale 1ns/1ps

module rs_entry (
  input  logic                      clock,
  input  logic                      rst_n,
  // Slot control from allocator and selector
  input  logic                      load,
  input  logic                      clear,
  // Dispatched instruction
  input  logic [rs_pkg::inst_w-1:0] inst,
  input  rs_pkg::alu_func_t         func,
  input  logic [rs_pkg::tag_w-1:0]  dest_tag,
  input  logic [rs_pkg::tag_w-1:0]  t1_tag,
  input  logic                      t1_ready,
  input  logic [rs_pkg::tag_w-1:0]  t2_tag,
  input  logic                      t2_ready,
  // CDB broadcast
  input  logic                      cdb_en,
  input  logic [rs_pkg::tag_w-1:0]  cdb_tag,
  // Slot state
  output logic                      busy,
  output logic                      ready,
  output logic [rs_pkg::inst_w-1:0] slot_inst,
  output rs_pkg::alu_func_t         slot_func,
  output logic [rs_pkg::tag_w-1:0]  slot_dest,
  output logic [rs_pkg::tag_w-1:0]  slot_t1,
  output logic [rs_pkg::tag_w-1:0]  slot_t2
);

  // Per-source ready bits
  logic t1_rdy;
  logic t2_rdy;

  // CDB match on incoming tags (bypass at load)
  logic byp_t1;
  logic byp_t2;

  // CDB match on held tags (wakeup)
  logic wake_t1;
  logic wake_t2;

  assign byp_t1  = cdb_en && (cdb_tag == t1_tag);
  assign byp_t2  = cdb_en && (cdb_tag == t2_tag);
  assign wake_t1 = cdb_en && (cdb_tag == slot_t1);
  assign wake_t2 = cdb_en && (cdb_tag == slot_t2);

  //////////////////////////////////////////////////
  // Slot register
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      t1_rdy    <= 1'b0;
      t2_rdy    <= 1'b0;
      slot_inst <= rs_pkg::noop_inst;
      slot_func <= rs_pkg::alu_addq;
      slot_dest <= '0;
      slot_t1   <= '0;
      slot_t2   <= '0;
    end else if (load) begin
      // Capture, a CDB hit this cycle counts as ready
      busy      <= 1'b1;
      t1_rdy    <= t1_ready | byp_t1;
      t2_rdy    <= t2_ready | byp_t2;
      slot_inst <= inst;
      slot_func <= func;
      slot_dest <= dest_tag;
      slot_t1   <= t1_tag;
      slot_t2   <= t2_tag;
    end else if (clear) begin
      // Issued, slot goes free
      busy   <= 1'b0;
      t1_rdy <= 1'b0;
      t2_rdy <= 1'b0;
    end else if (busy) begin
      // Wakeup only sets, never clears
      if (wake_t1) begin
        t1_rdy <= 1'b1;
      end
      if (wake_t2) begin
        t2_rdy <= 1'b1;
      end
    end
  end

  // Both operands available
  assign ready = busy & t1_rdy & t2_rdy;

endmodule

// ==== rs_alloc.sv ====
`timescale 1ns/1ps

module rs_alloc #(
  parameter int num_alu  = 4,
  parameter int num_mult = 2,
  parameter int num_ld   = 2,
  parameter int num_st   = 2,
  parameter int num_br   = 2
) (
  input  logic                                          dispatch_en,
  input  rs_pkg::fu_t                                   fu,
  input  logic [num_alu+num_mult+num_ld+num_st+num_br-1:0] busy,
  output logic [num_alu+num_mult+num_ld+num_st+num_br-1:0] load,
  output logic                                          rs_hazard
);

  localparam int num_rs = num_alu + num_mult + num_ld + num_st + num_br;

  // Class boundaries, layout ALU, mult, load, store, branch
  localparam int mult_lo = num_alu;
  localparam int ld_lo   = mult_lo + num_mult;
  localparam int st_lo   = ld_lo + num_ld;
  localparam int br_lo   = st_lo + num_st;

  logic [num_rs-1:0] in_class;
  logic [num_rs-1:0] free;
  logic [num_rs-1:0] pick;

  //////////////////////////////////////////////////
  // Class decode
  //////////////////////////////////////////////////

  always_comb begin
    in_class = '0;
    for (int i = 0; i < num_rs; i++) begin
      case (fu)
        rs_pkg::fu_alu:  in_class[i] = (i < mult_lo);
        rs_pkg::fu_mult: in_class[i] = (i >= mult_lo) && (i < ld_lo);
        rs_pkg::fu_ld:   in_class[i] = (i >= ld_lo) && (i < st_lo);
        rs_pkg::fu_st:   in_class[i] = (i >= st_lo) && (i < br_lo);
        rs_pkg::fu_br:   in_class[i] = (i >= br_lo);
        // Unknown class owns no slots
        default:         in_class[i] = 1'b0;
      endcase
    end
  end

  // Free slots of the requested class
  assign free = in_class & ~busy;

  // Lowest set bit, one-hot
  assign pick = free & (~free + 1'b1);

  // Load only on a real dispatch
  assign load = dispatch_en ? pick : '0;

  // Nothing free in this class
  assign rs_hazard = ~|free;

endmodule

// ==== rs_issue_select.sv ====
`timescale 1ns/1ps

module rs_issue_select #(
  parameter int n = 2
) (
  // Slice of this class's slots
  input  logic [n-1:0]                        ready,
  input  logic [n-1:0][rs_pkg::inst_w-1:0]    slot_inst,
  input  rs_pkg::alu_func_t [n-1:0]           slot_func,
  input  logic [n-1:0][rs_pkg::tag_w-1:0]     slot_dest,
  input  logic [n-1:0][rs_pkg::tag_w-1:0]     slot_t1,
  input  logic [n-1:0][rs_pkg::tag_w-1:0]     slot_t2,
  // Unit back-pressure
  input  logic                                fu_stall,
  // Free the issued slot
  output logic [n-1:0]                        clear,
  // Issue port to the unit
  output logic                                issue_valid,
  output logic [rs_pkg::inst_w-1:0]           issue_inst,
  output rs_pkg::alu_func_t                   issue_func,
  output logic [rs_pkg::tag_w-1:0]            issue_dest,
  output logic [rs_pkg::tag_w-1:0]            issue_t1,
  output logic [rs_pkg::tag_w-1:0]            issue_t2
);

  // One-hot of lowest ready slot
  logic [n-1:0] pick;

  assign pick = ready & (~ready + 1'b1);

  assign issue_valid = |ready;

  //////////////////////////////////////////////////
  // Payload mux
  //////////////////////////////////////////////////

  // Walk down so the lowest ready index wins
  always_comb begin
    issue_inst = '0;
    issue_func = rs_pkg::alu_addq;
    issue_dest = '0;
    issue_t1   = '0;
    issue_t2   = '0;
    for (int i = n - 1; i >= 0; i--) begin
      if (ready[i]) begin
        issue_inst = slot_inst[i];
        issue_func = slot_func[i];
        issue_dest = slot_dest[i];
        issue_t1   = slot_t1[i];
        issue_t2   = slot_t2[i];
      end
    end
  end

  // Stall keeps the slot; pick is zero when idle
  assign clear = (issue_valid && !fu_stall) ? pick : '0;

endmodule

// ==== rs.sv ====
`timescale 1ns/1ps

module rs #(
  parameter int num_alu  = 4,
  parameter int num_mult = 2,
  parameter int num_ld   = 2,
  parameter int num_st   = 2,
  parameter int num_br   = 2
) (
  input  logic                                       clock,
  input  logic                                       rst_n,
  // Dispatch
  input  logic                                       dispatch_en,
  input  rs_pkg::fu_t                                fu,
  input  rs_pkg::alu_func_t                          func,
  input  logic [rs_pkg::inst_w-1:0]                  inst,
  input  logic [rs_pkg::tag_w-1:0]                   dest_tag,
  input  logic [rs_pkg::tag_w-1:0]                   t1_tag,
  input  logic                                       t1_ready,
  input  logic [rs_pkg::tag_w-1:0]                   t2_tag,
  input  logic                                       t2_ready,
  // CDB
  input  logic                                       cdb_en,
  input  logic [rs_pkg::tag_w-1:0]                   cdb_tag,
  // Per class, indexed by fu_t code
  input  logic [rs_pkg::num_fu-1:0]                  fu_stall,
  output logic                                       rs_hazard,
  output logic [rs_pkg::num_fu-1:0]                  issue_valid,
  output logic [rs_pkg::num_fu-1:0][rs_pkg::inst_w-1:0] issue_inst,
  output rs_pkg::alu_func_t [rs_pkg::num_fu-1:0]     issue_func,
  output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0] issue_dest,
  output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0] issue_t1,
  output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0] issue_t2
);

  localparam int num_rs = num_alu + num_mult + num_ld + num_st + num_br;

  // Slot layout ALU, mult, load, store, branch
  localparam int class_n [rs_pkg::num_fu] = '{num_alu, num_mult, num_ld, num_st, num_br};
  localparam int class_base [rs_pkg::num_fu] = '{
    0,
    num_alu,
    num_alu + num_mult,
    num_alu + num_mult + num_ld,
    num_alu + num_mult + num_ld + num_st
  };
  // Issue port each layout class drives
  localparam rs_pkg::fu_t class_fu [rs_pkg::num_fu] = '{
    rs_pkg::fu_alu,
    rs_pkg::fu_mult,
    rs_pkg::fu_ld,
    rs_pkg::fu_st,
    rs_pkg::fu_br
  };

  // Slot-indexed state
  logic [num_rs-1:0]                     load;
  logic [num_rs-1:0]                     clear;
  logic [num_rs-1:0]                     busy;
  logic [num_rs-1:0]                     ready;
  logic [num_rs-1:0][rs_pkg::inst_w-1:0] slot_inst;
  rs_pkg::alu_func_t [num_rs-1:0]        slot_func;
  logic [num_rs-1:0][rs_pkg::tag_w-1:0]  slot_dest;
  logic [num_rs-1:0][rs_pkg::tag_w-1:0]  slot_t1;
  logic [num_rs-1:0][rs_pkg::tag_w-1:0]  slot_t2;

  //////////////////////////////////////////////////
  // Slots
  //////////////////////////////////////////////////

  for (genvar i = 0; i < num_rs; i++) begin : g_entry
    rs_entry entry_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (load[i]),
      .clear     (clear[i]),
      .inst      (inst),
      .func      (func),
      .dest_tag  (dest_tag),
      .t1_tag    (t1_tag),
      .t1_ready  (t1_ready),
      .t2_tag    (t2_tag),
      .t2_ready  (t2_ready),
      .cdb_en    (cdb_en),
      .cdb_tag   (cdb_tag),
      .busy      (busy[i]),
      .ready     (ready[i]),
      .slot_inst (slot_inst[i]),
      .slot_func (slot_func[i]),
      .slot_dest (slot_dest[i]),
      .slot_t1   (slot_t1[i]),
      .slot_t2   (slot_t2[i])
    );
  end

  // Lowest free slot of the dispatching class
  rs_alloc #(
    .num_alu  (num_alu),
    .num_mult (num_mult),
    .num_ld   (num_ld),
    .num_st   (num_st),
    .num_br   (num_br)
  ) alloc_i (
    .dispatch_en (dispatch_en),
    .fu          (fu),
    .busy        (busy),
    .load        (load),
    .rs_hazard   (rs_hazard)
  );

  //////////////////////////////////////////////////
  // Per-class issue
  //////////////////////////////////////////////////

  // Each selector owns its slice of clear
  for (genvar k = 0; k < rs_pkg::num_fu; k++) begin : g_class
    rs_issue_select #(
      .n (class_n[k])
    ) select_i (
      .ready       (ready[class_base[k] +: class_n[k]]),
      .slot_inst   (slot_inst[class_base[k] +: class_n[k]]),
      .slot_func   (slot_func[class_base[k] +: class_n[k]]),
      .slot_dest   (slot_dest[class_base[k] +: class_n[k]]),
      .slot_t1     (slot_t1[class_base[k] +: class_n[k]]),
      .slot_t2     (slot_t2[class_base[k] +: class_n[k]]),
      .fu_stall    (fu_stall[class_fu[k]]),
      .clear       (clear[class_base[k] +: class_n[k]]),
      .issue_valid (issue_valid[class_fu[k]]),
      .issue_inst  (issue_inst[class_fu[k]]),
      .issue_func  (issue_func[class_fu[k]]),
      .issue_dest  (issue_dest[class_fu[k]]),
      .issue_t1    (issue_t1[class_fu[k]]),
      .issue_t2    (issue_t2[class_fu[k]])
    );
  end

endmodule

// ==== tb_rs.sv ====
`timescale 1ns/1ps

module tb_rs;

  localparam int clk_period  = 100;
  // Rough length of all tests in cycles
  localparam int test_cycles = 150;

  logic                                          clock;
  logic                                          rst_n;
  logic                                          dispatch_en;
  rs_pkg::fu_t                                   fu;
  rs_pkg::alu_func_t                             func;
  logic [rs_pkg::inst_w-1:0]                     inst;
  logic [rs_pkg::tag_w-1:0]                      dest_tag;
  logic [rs_pkg::tag_w-1:0]                      t1_tag;
  logic                                          t1_ready;
  logic [rs_pkg::tag_w-1:0]                      t2_tag;
  logic                                          t2_ready;
  logic                                          cdb_en;
  logic [rs_pkg::tag_w-1:0]                      cdb_tag;
  logic [rs_pkg::num_fu-1:0]                     fu_stall;
  logic                                          rs_hazard;
  logic [rs_pkg::num_fu-1:0]                     issue_valid;
  logic [rs_pkg::num_fu-1:0][rs_pkg::inst_w-1:0] issue_inst;
  rs_pkg::alu_func_t [rs_pkg::num_fu-1:0]        issue_func;
  logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_dest;
  logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_t1;
  logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_t2;

  // ALU issues seen in the capacity test
  logic [rs_pkg::tag_w-1:0] seen_dest[$];
  logic [rs_pkg::tag_w-1:0] seen_t1[$];

  rs dut_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .dispatch_en (dispatch_en),
    .fu          (fu),
    .func        (func),
    .inst        (inst),
    .dest_tag    (dest_tag),
    .t1_tag      (t1_tag),
    .t1_ready    (t1_ready),
    .t2_tag      (t2_tag),
    .t2_ready    (t2_ready),
    .cdb_en      (cdb_en),
    .cdb_tag     (cdb_tag),
    .fu_stall    (fu_stall),
    .rs_hazard   (rs_hazard),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .issue_func  (issue_func),
    .issue_dest  (issue_dest),
    .issue_t1    (issue_t1),
    .issue_t2    (issue_t2)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // Hang guard allows twice the expected run
  initial begin
    #(2 * test_cycles * clk_period);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [rs_pkg::tag_w-1:0] rand_tag();
    logic [31:0] r;
    r = $urandom;
    return r[rs_pkg::tag_w-1:0];
  endfunction

  // Wait for the next edge and return strobes to idle 10 ns later
  task automatic tick();
    @(posedge clock);
    #10;
    dispatch_en = 1'b0;
    cdb_en      = 1'b0;
  endtask

  task automatic dispatch(input rs_pkg::fu_t f, input rs_pkg::alu_func_t op,
                          input logic [31:0] word, input logic [5:0] d,
                          input logic [5:0] s1, input logic s1_rdy,
                          input logic [5:0] s2, input logic s2_rdy);
    dispatch_en = 1'b1;
    fu          = f;
    func        = op;
    inst        = word;
    dest_tag    = d;
    t1_tag      = s1;
    t1_ready    = s1_rdy;
    t2_tag      = s2;
    t2_ready    = s2_rdy;
  endtask

  // Class port shows this payload
  task automatic expect_issue(input rs_pkg::fu_t c, input logic [31:0] word,
                              input rs_pkg::alu_func_t op, input logic [5:0] d,
                              input logic [5:0] s1, input logic [5:0] s2);
    check_value("issue_valid", issue_valid[c], 1'b1);
    check_value("issue_inst", issue_inst[c], word);
    check_value("issue_func", issue_func[c], op);
    check_value("issue_dest", issue_dest[c], d);
    check_value("issue_t1", issue_t1[c], s1);
    check_value("issue_t2", issue_t2[c], s2);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    check_value("issue_valid", issue_valid, '0);
    for (int i = 0; i < rs_pkg::num_fu; i++) begin
      fu = rs_pkg::fu_t'(i);
      #1;
      check_value("rs_hazard", rs_hazard, 1'b0);
    end
  endtask

  task automatic test_ready_dispatch();
    logic [31:0] word;
    logic [5:0]  d;
    logic [5:0]  s1;
    logic [5:0]  s2;
    word = $urandom;
    d    = rand_tag();
    s1   = rand_tag();
    s2   = rand_tag();
    dispatch(rs_pkg::fu_alu, rs_pkg::alu_cmplt, word, d, s1, 1'b1, s2, 1'b1);
    tick();
    expect_issue(rs_pkg::fu_alu, word, rs_pkg::alu_cmplt, d, s1, s2);
    // Issued at this edge so the slot is free again
    tick();
    check_value("issue_valid[alu]", issue_valid[rs_pkg::fu_alu], 1'b0);
  endtask

  task automatic test_wakeup_bypass();
    logic [31:0] word;
    logic [5:0]  d;
    logic [5:0]  ta;
    logic [5:0]  tb;
    word = $urandom;
    d    = rand_tag();
    ta   = rand_tag();
    tb   = ta ^ 6'h2a;
    // Multiply waits on two tags
    dispatch(rs_pkg::fu_mult, rs_pkg::alu_mulq, word, d, ta, 1'b0, tb, 1'b0);
    tick();
    check_value("issue_valid[mult]", issue_valid[rs_pkg::fu_mult], 1'b0);
    cdb_en  = 1'b1;
    cdb_tag = ta;
    tick();
    check_value("issue_valid[mult]", issue_valid[rs_pkg::fu_mult], 1'b0);
    cdb_en  = 1'b1;
    cdb_tag = tb;
    tick();
    expect_issue(rs_pkg::fu_mult, word, rs_pkg::alu_mulq, d, ta, tb);
    tick();
    check_value("issue_valid[mult]", issue_valid[rs_pkg::fu_mult], 1'b0);
    // Load catches its tag on the CDB while dispatching
    word = $urandom;
    d    = rand_tag();
    dispatch(rs_pkg::fu_ld, rs_pkg::alu_addq, word, d, ta, 1'b0, tb, 1'b1);
    cdb_en  = 1'b1;
    cdb_tag = ta;
    tick();
    expect_issue(rs_pkg::fu_ld, word, rs_pkg::alu_addq, d, ta, tb);
    tick();
    check_value("issue_valid[ld]", issue_valid[rs_pkg::fu_ld], 1'b0);
  endtask

  task automatic test_capacity();
    logic [5:0]  base;
    logic [5:0]  w[4];
    logic [5:0]  d[4];
    base = rand_tag();
    for (int k = 0; k < 4; k++) begin
      w[k] = base + 6'(k);
      d[k] = rand_tag();
      dispatch(rs_pkg::fu_alu, rs_pkg::alu_xor, $urandom, d[k], w[k], 1'b0,
               rand_tag(), 1'b1);
      tick();
    end
    fu = rs_pkg::fu_alu;
    #1;
    check_value("rs_hazard (alu)", rs_hazard, 1'b1);
    fu = rs_pkg::fu_br;
    #1;
    check_value("rs_hazard (br)", rs_hazard, 1'b0);
    // Fifth would wake with the last tag if it got in
    dispatch(rs_pkg::fu_alu, rs_pkg::alu_xor, $urandom, d[0] ^ 6'h15, w[3], 1'b0,
             rand_tag(), 1'b1);
    tick();
    for (int c = 0; c < 8; c++) begin
      if (c < 4) begin
        cdb_en  = 1'b1;
        cdb_tag = w[c];
      end
      tick();
      // Valid with no stall means it leaves at the next edge
      if (issue_valid[rs_pkg::fu_alu]) begin
        seen_dest.push_back(issue_dest[rs_pkg::fu_alu]);
        seen_t1.push_back(issue_t1[rs_pkg::fu_alu]);
      end
    end
    check_value("alu issue count", seen_dest.size(), 4);
    for (int k = 0; k < 4; k++) begin
      check_value("issue_dest[alu]", seen_dest[k], d[k]);
      check_value("issue_t1[alu]", seen_t1[k], w[k]);
    end
  endtask

  task automatic test_stall_order();
    logic [31:0] word[2];
    logic [5:0]  d[2];
    logic [5:0]  s[2];
    fu_stall[rs_pkg::fu_st] = 1'b1;
    for (int k = 0; k < 2; k++) begin
      word[k] = $urandom;
      d[k]    = rand_tag();
      s[k]    = rand_tag();
      dispatch(rs_pkg::fu_st, rs_pkg::alu_addq, word[k], d[k], s[k], 1'b1, s[k], 1'b1);
      tick();
    end
    // Held on the lower slot
    repeat (3) begin
      expect_issue(rs_pkg::fu_st, word[0], rs_pkg::alu_addq, d[0], s[0], s[0]);
      tick();
    end
    fu_stall[rs_pkg::fu_st] = 1'b0;
    expect_issue(rs_pkg::fu_st, word[0], rs_pkg::alu_addq, d[0], s[0], s[0]);
    tick();
    expect_issue(rs_pkg::fu_st, word[1], rs_pkg::alu_addq, d[1], s[1], s[1]);
    tick();
    check_value("issue_valid[st]", issue_valid[rs_pkg::fu_st], 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h8c4d));
    rst_n       = 1'b0;
    dispatch_en = 1'b0;
    fu          = rs_pkg::fu_alu;
    func        = rs_pkg::alu_addq;
    inst        = rs_pkg::noop_inst;
    dest_tag    = '0;
    t1_tag      = '0;
    t1_ready    = 1'b0;
    t2_tag      = '0;
    t2_ready    = 1'b0;
    cdb_en      = 1'b0;
    cdb_tag     = '0;
    fu_stall    = '0;
    repeat (4) @(posedge clock);
    #10;
    rst_n = 1'b1;
    test_reset();
    test_ready_dispatch();
    test_wakeup_bypass();
    test_capacity();
    test_stall_order();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
rs.sv
tb_rs.sv

// ==== Bender.yml ====
package:
  name: rs

sources:
  - rs_pkg.sv
  - rs_entry.sv
  - rs_alloc.sv
  - rs_issue_select.sv
  - rs.sv
  - target: test
    files:
      - tb_rs.sv
